// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tcdmPipelineTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+design
design/tcdmAddrPkg.sv
design/tcdmReqPkg.sv
design/addressScrambler.sv
design/bankDecoder.sv
design/tcdmBanks.sv
design/tcdmPipeline.sv
tb/tcdmPipelineTb.sv

// ==== design/addressScrambler.sv ====
`timescale 1ns/1ps
`include "tcdm_defines.svh"

// Stage 1 of the TCDM path
// Remaps the sequential region so each tile owns one contiguous block
module addressScrambler #(
  // Disables the remap, addresses keep the interleaved layout
  parameter bit Bypass = 1'b0
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 reqValid_i,
  input  tcdmReqPkg::req_t     req_i,
  output logic                 sValid_o,
  output tcdmReqPkg::req_t     sReq_o
);

  // Bits below the tile field stay in place (byte offset plus bank)
  localparam int unsigned ConstantBitsLsb = `BYTE_OFFSET + $clog2(`NUM_BANKS_PER_TILE);
  localparam int unsigned SeqPerTileBits  = $clog2(`SEQ_MEM_SIZE_PER_TILE);
  localparam int unsigned SeqTotalBits    = SeqPerTileBits + $clog2(`NUM_TILES);
  localparam int unsigned SeqTotalBytes   = `NUM_TILES * `SEQ_MEM_SIZE_PER_TILE;

  // Sequential block of a tile must hold whole bank rows
  if (`SEQ_MEM_SIZE_PER_TILE % ((2 ** `BYTE_OFFSET) * `NUM_BANKS_PER_TILE) != 0) begin : gCheck
    $fatal(1, "Sequential bytes per tile must be a multiple of bank width times banks");
  end

  tcdmAddrPkg::addr_t scrambledAddr;

  always_comb begin
    // Interleaved layout by default
    scrambledAddr = req_i.addr;
    // Swap the in-tile line bits below the tile-ID bits
    // Consecutive lines then stay inside one tile
    if (!Bypass && (req_i.addr < SeqTotalBytes)) begin
      scrambledAddr[SeqTotalBits-1:ConstantBitsLsb] = {
        req_i.addr[SeqPerTileBits-1:ConstantBitsLsb],
        req_i.addr[SeqTotalBits-1:SeqPerTileBits]
      };
    end
  end

  // Valid is control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sValid_o <= 1'b0;
    end else begin
      sValid_o <= reqValid_i;
    end
  end

  // Payload only loads with a request
  always_ff @(posedge clk_i) begin
    if (reqValid_i) begin
      sReq_o.opcode <= req_i.opcode;
      sReq_o.addr   <= scrambledAddr;
      sReq_o.wdata  <= req_i.wdata;
    end
  end

  // Interleaved addresses leave this stage untouched one cycle later
  assert property (@(posedge clk_i) disable iff (rst_i)
    (reqValid_i && (req_i.addr >= SeqTotalBytes)) |=>
      (sValid_o && (sReq_o.addr == $past(req_i.addr))))
  else $error("Address outside the sequential region was altered by the scrambler");

endmodule

// ==== design/bankDecoder.sv ====
`timescale 1ns/1ps
`include "tcdm_defines.svh"

// Stage 2 of the TCDM path
// Splits the scrambled address into tile, bank and row
module bankDecoder (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   sValid_i,
  input  tcdmReqPkg::req_t       sReq_i,
  output logic                   dValid_o,
  output tcdmReqPkg::stagedReq_t dReq_o
);

  // Field positions of the interleaved layout
  // Byte offset bits below BankLsb are dropped
  localparam int unsigned BankLsb  = `BYTE_OFFSET;
  localparam int unsigned BankBits = $bits(tcdmAddrPkg::bankId_t);
  localparam int unsigned TileLsb  = BankLsb + BankBits;
  localparam int unsigned TileBits = $bits(tcdmAddrPkg::tileId_t);
  localparam int unsigned RowLsb   = TileLsb + TileBits;
  localparam int unsigned RowBits  = $bits(tcdmAddrPkg::row_t);
  // First bit past the end of the memory
  localparam int unsigned RangeLsb = RowLsb + RowBits;

  tcdmAddrPkg::decodedAddr_t decoded;
  logic                      outOfRange;

  always_comb begin
    decoded.bank = sReq_i.addr[BankLsb +: BankBits];
    decoded.tile = sReq_i.addr[TileLsb +: TileBits];
    decoded.row  = sReq_i.addr[RowLsb +: RowBits];
    // Any high bit means the word is not in the TCDM
    outOfRange   = |sReq_i.addr[`ADDR_WIDTH-1:RangeLsb];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dValid_o <= 1'b0;
    end else begin
      dValid_o <= sValid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sValid_i) begin
      dReq_o.opcode     <= sReq_i.opcode;
      dReq_o.addr       <= decoded;
      dReq_o.outOfRange <= outOfRange;
      dReq_o.wdata      <= sReq_i.wdata;
    end
  end

  // Nothing leaves the decoder right after reset
  assert property (@(posedge clk_i) rst_i |=> !dValid_o)
  else $error("Decoder output valid high in the cycle after reset");

endmodule

// ==== design/tcdmAddrPkg.sv ====
`include "tcdm_defines.svh"

// Address field types of the TCDM
package tcdmAddrPkg;

  // Full core address as issued by the core
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // Tile index
  typedef logic [$clog2(`NUM_TILES)-1:0] tileId_t;

  // Bank index inside a tile
  typedef logic [$clog2(`NUM_BANKS_PER_TILE)-1:0] bankId_t;

  // Word line inside a bank
  typedef logic [$clog2(`ROWS_PER_BANK)-1:0] row_t;

  // Decoded location of one word
  // Tile sits in the MSBs, row in the LSBs
  // Together they index the whole bank array
  typedef struct packed {
    // Which tile serves the word
    tileId_t tile;
    // Which bank inside that tile
    bankId_t bank;
    // Which line inside that bank
    row_t    row;
  } decodedAddr_t;

  // Interleaved layout of a scrambled address, from LSB upward
  //   byte offset  2 bits
  //   bank         2 bits
  //   tile         2 bits
  //   row          6 bits
  // Anything above the row field is outside the memory

endpackage

// ==== design/tcdmBanks.sv ====
`timescale 1ns/1ps
`include "tcdm_defines.svh"

// Stage 3 of the TCDM path
// Bank array of all tiles, performs the access and registers the response
module tcdmBanks (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   dValid_i,
  input  tcdmReqPkg::stagedReq_t dReq_i,
  output logic                   rspValid_o,
  output tcdmReqPkg::rsp_t       rsp_o
);

  // Words of every bank in every tile
  tcdmReqPkg::data_t mem [`NUM_TILES][`NUM_BANKS_PER_TILE][`ROWS_PER_BANK];

  logic doWrite;
  logic doRead;

  // Out-of-range accesses never touch the array
  always_comb begin
    doWrite = dValid_i && (dReq_i.opcode == tcdmReqPkg::OP_WRITE) && !dReq_i.outOfRange;
    doRead  = dValid_i && (dReq_i.opcode == tcdmReqPkg::OP_READ) && !dReq_i.outOfRange;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rspValid_o <= 1'b0;
    end else begin
      rspValid_o <= dValid_i;
    end
  end

  // Array write port
  always_ff @(posedge clk_i) begin
    if (doWrite) begin
      mem[dReq_i.addr.tile][dReq_i.addr.bank][dReq_i.addr.row] <= dReq_i.wdata;
    end
  end

  // Response register
  always_ff @(posedge clk_i) begin
    if (dValid_i) begin
      rsp_o.opcode <= dReq_i.opcode;
      rsp_o.err    <= dReq_i.outOfRange;
      rsp_o.tile   <= dReq_i.addr.tile;
      rsp_o.bank   <= dReq_i.addr.bank;
      // Writes and errors return zero
      if (doRead) begin
        rsp_o.rdata <= mem[dReq_i.addr.tile][dReq_i.addr.bank][dReq_i.addr.row];
      end else begin
        rsp_o.rdata <= '0;
      end
    end
  end

  // Out-of-range request comes back next cycle as an error with zero data
  assert property (@(posedge clk_i) disable iff (rst_i)
    (dValid_i && dReq_i.outOfRange) |=>
      (rspValid_o && rsp_o.err && (rsp_o.rdata == '0)))
  else $error("Out-of-range access did not return an error with zero data");

endmodule

// ==== design/tcdmPipeline.sv ====
`timescale 1ns/1ps
`include "tcdm_defines.svh"

// Word-access path into the TCDM
// Scramble, decode and bank access, one cycle each
module tcdmPipeline (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             reqValid_i,
  input  tcdmReqPkg::req_t req_i,
  output logic             rspValid_o,
  output tcdmReqPkg::rsp_t rsp_o
);

  // Stage 1 to stage 2
  logic                   sValid;
  tcdmReqPkg::req_t       sReq;
  // Stage 2 to stage 3
  logic                   dValid;
  tcdmReqPkg::stagedReq_t dReq;

  addressScrambler #(
    .Bypass (1'b0)
  ) i_addressScrambler (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .reqValid_i (reqValid_i),
    .req_i      (req_i),
    .sValid_o   (sValid),
    .sReq_o     (sReq)
  );

  bankDecoder i_bankDecoder (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .sValid_i (sValid),
    .sReq_i   (sReq),
    .dValid_o (dValid),
    .dReq_o   (dReq)
  );

  tcdmBanks i_tcdmBanks (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .dValid_i   (dValid),
    .dReq_i     (dReq),
    .rspValid_o (rspValid_o),
    .rsp_o      (rsp_o)
  );

endmodule

// ==== design/tcdmReqPkg.sv ====
`include "tcdm_defines.svh"

// Transaction types of the TCDM access path
package tcdmReqPkg;

  // Access kind
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } opcode_e;

  // One memory word
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // Request as issued by the core
  typedef struct packed {
    opcode_e            opcode;
    tcdmAddrPkg::addr_t addr;
    data_t              wdata;
  } req_t;

  // Request after decoding, address replaced by its fields
  typedef struct packed {
    opcode_e                   opcode;
    tcdmAddrPkg::decodedAddr_t addr;
    // Set for addresses beyond the TCDM
    logic                      outOfRange;
    data_t                     wdata;
  } stagedReq_t;

  // Response to the core
  // Tile and bank are echoed for activity counting
  typedef struct packed {
    opcode_e              opcode;
    data_t                rdata;
    logic                 err;
    tcdmAddrPkg::tileId_t tile;
    tcdmAddrPkg::bankId_t bank;
  } rsp_t;

endpackage

// ==== design/tcdm_defines.svh ====
`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

// Width of a core address
`define ADDR_WIDTH 32

// Byte bits inside one 32-bit word
// These are never used to select a bank
`define BYTE_OFFSET 2

// Tile and bank geometry of the TCDM
`define NUM_TILES 4
`define NUM_BANKS_PER_TILE 4

// Words held by each bank
// Total TCDM size is 4 tiles x 4 banks x 64 words x 4 bytes = 4 KiB
`define ROWS_PER_BANK 64

// Bytes of the sequential region owned by one tile
// Sequential region spans 0 .. NUM_TILES*256-1
`define SEQ_MEM_SIZE_PER_TILE 256

// Width of a memory word
`define DATA_WIDTH 32

`endif

// ==== tb/tcdmPipelineTb.sv ====
`timescale 1ns/1ps
`include "tcdm_defines.svh"

// Self-checking testbench for the TCDM word-access path
module tcdmPipelineTb;

  localparam int FillWords   = 1024;
  localparam int LatencyReqs = 4;
  localparam int SeqWords    = 128;
  localparam int IlvWords    = 32;
  localparam int OorPairs    = 9;
  localparam int RandCount   = 300;
  localparam int TotalReqs   = FillWords + LatencyReqs + 2 * (SeqWords + IlvWords + OorPairs)
                               + RandCount;
  // Three cycles per request covers isolated accesses and drains
  localparam int WatchdogCycles = TotalReqs * 3 + 200;
  localparam int DrainLimit     = 20;

  logic             clk = 1'b0;
  logic             rst;
  logic             reqValid;
  tcdmReqPkg::req_t req;
  logic             rspValid;
  tcdmReqPkg::rsp_t rsp;

  // Expected responses, and the cycle each one is due in
  tcdmReqPkg::rsp_t  expQ[$];
  int                dueQ[$];
  // Shadow copy of the bank array
  tcdmReqPkg::data_t shadow [`NUM_TILES][`NUM_BANKS_PER_TILE][`ROWS_PER_BANK];
  logic [31:0]       lcgState = 32'hcb49_4b8f;
  int                cycleCnt = 0;
  string             testName = "reset";
  int                testErrors = 0;
  int                errorCount = 0;
  int                checkCount = 0;
  int                testCount = 0;
  int                failCount = 0;
  tcdmReqPkg::rsp_t  expRsp;
  int                dueCycle;

  tcdmPipeline i_tcdmPipeline (
    .clk_i      (clk),
    .rst_i      (rst),
    .reqValid_i (reqValid),
    .req_i      (req),
    .rspValid_o (rspValid),
    .rsp_o      (rsp)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Sequential region, line bits 7..4 move above the tile-ID bits 9..8
  function automatic tcdmAddrPkg::addr_t scrambleRef(input tcdmAddrPkg::addr_t a);
    tcdmAddrPkg::addr_t s;
    s = a;
    if (a < 32'd1024) begin
      s[9:4] = {a[7:4], a[9:8]};
    end
    return s;
  endfunction

  // Expected response from the address rules and the shadow memory
  function automatic tcdmReqPkg::rsp_t refModel(input tcdmReqPkg::opcode_e op,
                                                input tcdmAddrPkg::addr_t a);
    tcdmAddrPkg::addr_t s;
    tcdmReqPkg::rsp_t   r;
    s = scrambleRef(a);
    r.opcode = op;
    r.bank   = s[3:2];
    r.tile   = s[5:4];
    // Anything from bit 12 up lies past the 4 KiB array
    r.err    = |s[31:12];
    r.rdata  = '0;
    if ((op == tcdmReqPkg::OP_READ) && !r.err) begin
      r.rdata = shadow[s[5:4]][s[3:2]][s[11:6]];
    end
    return r;
  endfunction

  task automatic noteError();
    testErrors++;
    errorCount++;
  endtask

  task automatic checkData(input tcdmReqPkg::data_t expData, input tcdmReqPkg::data_t actData);
    checkCount++;
    if (actData !== expData) begin
      $display("ERROR %s rdata: expected %h, actual %h", testName, expData, actData);
      noteError();
    end
  endtask

  task automatic checkTileBank(input tcdmAddrPkg::tileId_t expTile,
                               input tcdmAddrPkg::bankId_t expBank,
                               input tcdmAddrPkg::tileId_t actTile,
                               input tcdmAddrPkg::bankId_t actBank);
    checkCount++;
    if ((actTile !== expTile) || (actBank !== expBank)) begin
      $display("ERROR %s tile/bank: expected %0d/%0d, actual %0d/%0d",
               testName, expTile, expBank, actTile, actBank);
      noteError();
    end
  endtask

  task automatic checkErr(input bit expErr, input logic actErr);
    checkCount++;
    if (actErr !== expErr) begin
      $display("ERROR %s err flag: expected %0b, actual %0b", testName, expErr, actErr);
      noteError();
    end
  endtask

  // Response must echo the access kind of its request
  task automatic checkOpcode(input tcdmReqPkg::opcode_e expOp,
                             input tcdmReqPkg::opcode_e actOp);
    checkCount++;
    if (actOp !== expOp) begin
      $display("ERROR %s opcode: expected %0b, actual %0b", testName, expOp, actOp);
      noteError();
    end
  endtask

  // One request, driven 2 ns after the edge and held for one cycle
  task automatic drive(input tcdmReqPkg::opcode_e op, input tcdmAddrPkg::addr_t a,
                       input tcdmReqPkg::data_t d);
    tcdmAddrPkg::addr_t s;
    @(posedge clk);
    #2;
    reqValid   = 1'b1;
    req.opcode = op;
    req.addr   = a;
    req.wdata  = d;
    expQ.push_back(refModel(op, a));
    dueQ.push_back(cycleCnt + 3);
    s = scrambleRef(a);
    // Out-of-range writes leave the memory alone
    if ((op == tcdmReqPkg::OP_WRITE) && (s[31:12] == '0)) begin
      shadow[s[5:4]][s[3:2]][s[11:6]] = d;
    end
  endtask

  task automatic idle();
    @(posedge clk);
    #2;
    reqValid = 1'b0;
  endtask

  // Waits for all outstanding responses, then a little longer for stray pulses
  task automatic waitDrain();
    int n;
    n = 0;
    while ((expQ.size() != 0) && (n < DrainLimit)) begin
      @(posedge clk);
      n++;
    end
    if (expQ.size() != 0) begin
      $display("Test %s: %0d responses never arrived", testName, expQ.size());
      noteError();
      expQ.delete();
      dueQ.delete();
    end
    repeat (3) @(posedge clk);
  endtask

  task automatic beginTest(input string name);
    testName   = name;
    testErrors = 0;
  endtask

  task automatic endTest();
    testCount++;
    if (testErrors == 0) begin
      $display("Test %s passed", testName);
    end else begin
      $display("Test %s failed with %0d errors", testName, testErrors);
      failCount++;
    end
  endtask

  // Back-to-back writes of consecutive words, then reads of the same words
  task automatic writeReadRange(input string name, input tcdmAddrPkg::addr_t base,
                                input int words);
    beginTest(name);
    for (int w = 0; w < words; w++) begin
      drive(tcdmReqPkg::OP_WRITE, base + w * 4, nextRand());
    end
    for (int w = 0; w < words; w++) begin
      drive(tcdmReqPkg::OP_READ, base + w * 4, '0);
    end
    idle();
    waitDrain();
    endTest();
  endtask

  task automatic runLatency();
    beginTest("latency");
    // Quiet pipeline after reset, the monitor flags any pulse here
    repeat (6) @(posedge clk);
    drive(tcdmReqPkg::OP_WRITE, 32'h0000_0840, 32'hdead_beef);
    idle();
    waitDrain();
    drive(tcdmReqPkg::OP_READ, 32'h0000_0840, '0);
    idle();
    waitDrain();
    drive(tcdmReqPkg::OP_WRITE, 32'h0000_0104, 32'h1234_5678);
    idle();
    waitDrain();
    drive(tcdmReqPkg::OP_READ, 32'h0000_0104, '0);
    idle();
    waitDrain();
    endTest();
  endtask

  task automatic runFill();
    tcdmAddrPkg::addr_t a;
    beginTest("fill");
    for (int w = 0; w < FillWords; w++) begin
      a = w * 4;
      drive(tcdmReqPkg::OP_WRITE, a, {~a[15:0], a[15:0]});
    end
    idle();
    waitDrain();
    endTest();
  endtask

  task automatic runOutOfRange();
    tcdmAddrPkg::addr_t hi;
    beginTest("out_of_range");
    for (int k = 0; k < OorPairs; k++) begin
      hi = (k + 1) * 4096 + 1024 + k * 52;
      if (k == OorPairs - 1) begin
        hi = 32'hffff_fff0;
      end
      drive(tcdmReqPkg::OP_WRITE, hi, nextRand());
      // Alias in range must still hold its earlier value
      drive(tcdmReqPkg::OP_READ, hi & 32'h0000_0fff, '0);
    end
    idle();
    waitDrain();
    endTest();
  endtask

  task automatic runRandom();
    logic [31:0]         r;
    tcdmAddrPkg::addr_t  a;
    tcdmAddrPkg::addr_t  lastAddr;
    tcdmReqPkg::opcode_e op;
    beginTest("random");
    lastAddr = '0;
    for (int i = 0; i < RandCount; i++) begin
      r  = nextRand();
      a  = ((r >> 8) % 32'd1251) << 2;
      op = r[31] ? tcdmReqPkg::OP_WRITE : tcdmReqPkg::OP_READ;
      // Every 25 requests a write is followed at once by a read of its address
      if (i % 25 == 0) begin
        op = tcdmReqPkg::OP_WRITE;
      end else if (i % 25 == 1) begin
        op = tcdmReqPkg::OP_READ;
        a  = lastAddr;
      end
      drive(op, a, nextRand());
      lastAddr = a;
    end
    idle();
    waitDrain();
    endTest();
  endtask

  // Response monitor, samples at the falling edge where outputs are stable
  always @(negedge clk) begin
    if (!rst) begin
      if (rspValid === 1'b1) begin
        if (expQ.size() == 0) begin
          $display("Test %s: response pulse with no request outstanding", testName);
          noteError();
        end else begin
          expRsp   = expQ.pop_front();
          dueCycle = dueQ.pop_front();
          if (cycleCnt != dueCycle) begin
            $display("Test %s: response came in cycle %0d but was due in cycle %0d",
                     testName, cycleCnt, dueCycle);
            noteError();
          end
          checkOpcode(expRsp.opcode, rsp.opcode);
          checkData(expRsp.rdata, rsp.rdata);
          checkTileBank(expRsp.tile, expRsp.bank, rsp.tile, rsp.bank);
          checkErr(expRsp.err, rsp.err);
        end
      end else if (rspValid !== 1'b0) begin
        $display("Test %s: response valid is unknown", testName);
        noteError();
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst      = 1'b1;
    reqValid = 1'b0;
    req      = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    runLatency();
    runFill();
    // Words 0..63 land in tile 0, words 64..127 in tile 1
    writeReadRange("sequential", 32'h0000_0000, SeqWords);
    writeReadRange("interleaved", 32'h0000_0400, IlvWords);
    runOutOfRange();
    runRandom();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, failCount, checkCount, errorCount);
    if ((errorCount == 0) && (failCount == 0)) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
